// File: Makefile
TOP := line_buf_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f line_buf.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: line_buf.f
logic/line_buf_data_pkg.sv
logic/line_buf_geom_pkg.sv
logic/line_bank_ram.sv
logic/line_write_scatter.sv
logic/line_read_gather.sv
logic/line_buf.sv
verif/line_buf_clkgen.sv
verif/line_buf_tb.sv

// File: logic/line_bank_ram.sv
// Half-row writable bank memory
`timescale 1ns/100ps
`default_nettype none

module line_bank_ram (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire line_buf_data_pkg::half_en_t  we_i,
	input  wire line_buf_data_pkg::row_addr_t wr_addr_i,
	input  wire line_buf_data_pkg::seg_t      wr_data_i,
	input  wire                               re_i,
	input  wire line_buf_data_pkg::row_addr_t rd_addr_i,
	output line_buf_data_pkg::seg_t           rd_data_o
);

	localparam int ROWS   = 2**$bits(line_buf_data_pkg::row_addr_t);
	localparam int HALF_W = $bits(line_buf_data_pkg::half_t);

	// One 8-pixel segment per row
	line_buf_data_pkg::seg_t mem [ROWS];
	line_buf_data_pkg::seg_t rd_q;

	// Write port with its own enable for each half
	always_ff @(posedge clk) begin
		if (we_i[1])
			mem[wr_addr_i][2*HALF_W-1:HALF_W] <= wr_data_i[2*HALF_W-1:HALF_W];
		if (we_i[0])
			mem[wr_addr_i][HALF_W-1:0] <= wr_data_i[HALF_W-1:0];
	end

	// Read port returns old data on a same-row collision
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_q <= '0;
		end else if (re_i) begin
			rd_q <= mem[rd_addr_i];
		end
	end

	assign rd_data_o = rd_q;

endmodule

`default_nettype wire

// File: logic/line_buf.sv
// Four-bank pixel line buffer
`timescale 1ns/100ps
`default_nettype none

module line_buf (
	input  wire                               clk,
	input  wire                               rst_n,
	// Port A write side
	input  wire                               wr_en_i,
	input  wire  line_buf_geom_pkg::blk_pos_t wr_pos_i,
	input  wire  line_buf_data_pkg::line_t    wr_line_i,
	// Port B read side
	input  wire                               rd_en_i,
	input  wire  line_buf_geom_pkg::blk_pos_t rd_pos_i,
	output line_buf_data_pkg::line_t          rd_line_o
);

	// Port A per-bank write controls
	line_buf_data_pkg::half_en_t  [line_buf_data_pkg::NUM_BANKS-1:0] bank_we;
	line_buf_data_pkg::row_addr_t [line_buf_data_pkg::NUM_BANKS-1:0] bank_wr_addr;
	line_buf_data_pkg::seg_t      [line_buf_data_pkg::NUM_BANKS-1:0] bank_wr_data;
	// Port B per-bank read controls and data
	logic                         [line_buf_data_pkg::NUM_BANKS-1:0] bank_re;
	line_buf_data_pkg::row_addr_t [line_buf_data_pkg::NUM_BANKS-1:0] bank_rd_addr;
	line_buf_data_pkg::seg_t      [line_buf_data_pkg::NUM_BANKS-1:0] bank_rd_data;

	line_write_scatter i_scatter (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en_i     (wr_en_i),
		.wr_pos_i    (wr_pos_i),
		.wr_line_i   (wr_line_i),
		.bank_we_o   (bank_we),
		.bank_addr_o (bank_wr_addr),
		.bank_data_o (bank_wr_data)
	);

	//**************************************************************************
	// Memory banks
	//**************************************************************************

	for (genvar b = 0; b < line_buf_data_pkg::NUM_BANKS; b++) begin : g_bank
		line_bank_ram i_ram (
			.clk       (clk),
			.rst_n     (rst_n),
			.we_i      (bank_we[b]),
			.wr_addr_i (bank_wr_addr[b]),
			.wr_data_i (bank_wr_data[b]),
			.re_i      (bank_re[b]),
			.rd_addr_i (bank_rd_addr[b]),
			.rd_data_o (bank_rd_data[b])
		);
	end

	line_read_gather i_gather (
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_en_i     (rd_en_i),
		.rd_pos_i    (rd_pos_i),
		.bank_data_i (bank_rd_data),
		.bank_re_o   (bank_re),
		.bank_addr_o (bank_rd_addr),
		.rd_line_o   (rd_line_o)
	);

endmodule

`default_nettype wire

// File: logic/line_buf_data_pkg.sv
// Line buffer pixel data types
`default_nettype none

package line_buf_data_pkg;

	//**************************************************************************
	// Buffer organization
	//**************************************************************************

	// Banks behind the two ports
	localparam int NUM_BANKS = 4;
	// One 8-pixel segment per bank row
	localparam int SEGS_PER_LINE = 4;

	// Bank number and segment slot
	typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
	typedef logic [$clog2(SEGS_PER_LINE)-1:0] seg_idx_t;

	//**************************************************************************
	// Pixel payload
	//**************************************************************************

	typedef logic [7:0] pixel_t;
	// Four pixels, half a bank row
	typedef logic [4*$bits(pixel_t)-1:0] half_t;
	// Eight pixels, one full bank row
	typedef logic [8*$bits(pixel_t)-1:0] seg_t;
	// Whole line, segment 0 in the top bits
	typedef logic [SEGS_PER_LINE*$bits(seg_t)-1:0] line_t;

	// Row address inside one bank, 128 rows
	typedef logic [6:0] row_addr_t;
	// Bit 1 upper half, bit 0 lower half
	typedef logic [1:0] half_en_t;

endpackage

`default_nettype wire

// File: logic/line_buf_geom_pkg.sv
// Line buffer block geometry
`default_nettype none

package line_buf_geom_pkg;

	// Block size code
	typedef enum logic [1:0] {
		size_4x4   = 2'b00,
		size_8x8   = 2'b01,
		size_16x16 = 2'b10,
		size_32x32 = 2'b11
	} blk_size_e;

	// 4x4-block coordinate and row index in the block
	typedef logic [3:0] blk_coord_t;
	typedef logic [4:0] blk_idx_t;
	// Rotation of segments over the banks
	typedef logic [1:0] skew_t;

	// Block position, size in the top bits
	typedef struct packed {
		blk_size_e  size;
		blk_coord_t x;
		blk_coord_t y;
		blk_idx_t   idx;
	} blk_pos_t;

	//**************************************************************************
	// Bank mapping
	//**************************************************************************

	// Skew is the size dependent key with its two bits swapped
	function automatic skew_t bank_skew(blk_pos_t pos);
		skew_t key;
		case (pos.size)
			size_4x4, size_8x8: key = pos.x[2:1];
			size_16x16:         key = {pos.x[2], pos.idx[1]};
			default:            key = pos.idx[1:0];
		endcase
		return {key[0], key[1]};
	endfunction

	// Bank that holds segment k
	function automatic line_buf_data_pkg::bank_idx_t seg_bank(blk_pos_t pos,
			line_buf_data_pkg::seg_idx_t k);
		return k + bank_skew(pos);
	endfunction

	// Inverse of seg_bank, segment that lands in bank b
	function automatic line_buf_data_pkg::seg_idx_t bank_seg(blk_pos_t pos,
			line_buf_data_pkg::bank_idx_t b);
		return b - bank_skew(pos);
	endfunction

	// Row of segment k, top bits pick the 32x32 quadrant
	function automatic line_buf_data_pkg::row_addr_t seg_row(blk_pos_t pos,
			line_buf_data_pkg::seg_idx_t k);
		logic [2:0] mid;
		case (pos.size)
			size_4x4:   mid = pos.y[2:0];
			size_8x8:   mid = {pos.y[2:1], pos.idx[2]};
			size_16x16: mid = {pos.y[2], pos.idx[3:2]};
			default:    mid = pos.idx[4:2];
		endcase
		return {pos.y[3], pos.x[3], mid, k};
	endfunction

endpackage

`default_nettype wire

// File: logic/line_read_gather.sv
// Port B read gather
`timescale 1ns/100ps
`default_nettype none

module line_read_gather (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire                                rd_en_i,
	input  wire  line_buf_geom_pkg::blk_pos_t  rd_pos_i,
	input  wire  line_buf_data_pkg::seg_t      [line_buf_data_pkg::NUM_BANKS-1:0] bank_data_i,
	output logic [line_buf_data_pkg::NUM_BANKS-1:0]                              bank_re_o,
	output line_buf_data_pkg::row_addr_t [line_buf_data_pkg::NUM_BANKS-1:0] bank_addr_o,
	output line_buf_data_pkg::line_t     rd_line_o
);

	localparam int SEG_W = $bits(line_buf_data_pkg::seg_t);
	localparam int SEGS  = line_buf_data_pkg::SEGS_PER_LINE;

	// Position of the last read held until the next read
	line_buf_geom_pkg::blk_pos_t pos_q;

	//**************************************************************************
	// Read request
	//**************************************************************************

	// All banks take part in every read
	assign bank_re_o = {line_buf_data_pkg::NUM_BANKS{rd_en_i}};

	for (genvar b = 0; b < line_buf_data_pkg::NUM_BANKS; b++) begin : g_addr
		// Same row rule as the write side
		assign bank_addr_o[b] = line_buf_geom_pkg::seg_row(rd_pos_i,
			line_buf_geom_pkg::bank_seg(rd_pos_i, line_buf_data_pkg::bank_idx_t'(b)));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_q <= '0;
		end else if (rd_en_i) begin
			pos_q <= rd_pos_i;
		end
	end

	//**************************************************************************
	// Reorder bank outputs into line order
	//**************************************************************************

	for (genvar k = 0; k < SEGS; k++) begin : g_slot
		// Bank output register and pos_q change on the same edge
		assign rd_line_o[(SEGS-1-k)*SEG_W +: SEG_W] =
			bank_data_i[line_buf_geom_pkg::seg_bank(pos_q, line_buf_data_pkg::seg_idx_t'(k))];
	end

	// Banks must return defined data for every read
	a_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en_i |=> !$isunknown(rd_line_o));

endmodule

`default_nettype wire

// File: logic/line_write_scatter.sv
// Port A write scatter
`timescale 1ns/100ps
`default_nettype none

module line_write_scatter (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               wr_en_i,
	input  wire line_buf_geom_pkg::blk_pos_t  wr_pos_i,
	input  wire line_buf_data_pkg::line_t     wr_line_i,
	output line_buf_data_pkg::half_en_t  [line_buf_data_pkg::NUM_BANKS-1:0] bank_we_o,
	output line_buf_data_pkg::row_addr_t [line_buf_data_pkg::NUM_BANKS-1:0] bank_addr_o,
	output line_buf_data_pkg::seg_t      [line_buf_data_pkg::NUM_BANKS-1:0] bank_data_o
);

	// Slice widths inside a line
	localparam int SEG_W  = $bits(line_buf_data_pkg::seg_t);
	localparam int HALF_W = $bits(line_buf_data_pkg::half_t);
	localparam int SEGS   = line_buf_data_pkg::SEGS_PER_LINE;

	// 4x4 mode writes half rows
	logic is_4x4;
	// Half selected by x bit 0 with the upper half for even blocks
	line_buf_data_pkg::half_en_t half_sel;

	assign is_4x4   = (wr_pos_i.size == line_buf_geom_pkg::size_4x4);
	assign half_sel = is_4x4 ? {~wr_pos_i.x[0], wr_pos_i.x[0]} : 2'b11;

	//**************************************************************************
	// Per-bank address, data and enables
	//**************************************************************************

	for (genvar b = 0; b < line_buf_data_pkg::NUM_BANKS; b++) begin : g_bank
		// Segment this bank receives under the current skew
		line_buf_data_pkg::seg_idx_t seg;
		// Full segment and 4-pixel row picked from the line
		line_buf_data_pkg::seg_t  full_seg;
		line_buf_data_pkg::half_t quad_row;

		assign seg = line_buf_geom_pkg::bank_seg(wr_pos_i,
			line_buf_data_pkg::bank_idx_t'(b));

		// Segment k sits at slot k from the top of the line
		assign full_seg = wr_line_i[(SEGS-1-int'(seg))*SEG_W +: SEG_W];
		// 4x4 rows live in the upper half of the line with row 0 on top
		assign quad_row = wr_line_i[(2*SEGS-1-int'(seg))*HALF_W +: HALF_W];

		assign bank_addr_o[b] = line_buf_geom_pkg::seg_row(wr_pos_i, seg);
		// Row copied to both halves so the enable picks the one written
		assign bank_data_o[b] = is_4x4 ? {quad_row, quad_row} : full_seg;
		assign bank_we_o[b]   = wr_en_i ? half_sel : 2'b00;

		// A 4x4 write must hit exactly one half of every bank row
		a_half_onehot: assert property (@(posedge clk) disable iff (!rst_n)
			(wr_en_i && is_4x4) |-> $onehot(bank_we_o[b]));
	end

endmodule

`default_nettype wire

// File: verif/line_buf_clkgen.sv
// Testbench clock source
`timescale 1ns/100ps
`default_nettype none

module line_buf_clkgen #(
	parameter int HALF_PERIOD = 5
) (
	output logic clk_o
);

	// Free running, starts low so the first edge is a rising one
	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// File: verif/line_buf_tb.sv
// Line buffer testbench
`timescale 1ns/100ps
`default_nettype none

module line_buf_tb;

	// One record of the tests file
	typedef struct packed {
		logic [3:0]                    op;
		logic [3:0]                    size;
		line_buf_geom_pkg::blk_coord_t x;
		line_buf_geom_pkg::blk_coord_t y;
		logic [7:0]                    idx;
		line_buf_data_pkg::line_t      data;
	} test_rec_t;

	localparam int REC_W        = $bits(test_rec_t);
	localparam int MAX_RECS     = 64;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_PERIOD   = 10;

	// Op code flag bits, all ones ends the list
	localparam int         OP_WR_BIT    = 0;
	localparam int         OP_RD_BIT    = 1;
	localparam int         OP_HOLD_BIT  = 2;
	localparam int         OP_CHECK_BIT = 3;
	localparam logic [3:0] OP_END       = 4'hf;

	logic                        clk;
	logic                        rst_n;
	logic                        wr_en;
	line_buf_geom_pkg::blk_pos_t wr_pos;
	line_buf_data_pkg::line_t    wr_line;
	logic                        rd_en;
	line_buf_geom_pkg::blk_pos_t rd_pos;
	line_buf_data_pkg::line_t    rd_line;

	logic [REC_W-1:0] tests [MAX_RECS];
	int               num_recs;
	int               seed;
	// Read in flight, checked one cycle after it was issued
	logic                     pend_valid;
	line_buf_data_pkg::line_t pend_exp;
	int                       pend_rec;

	line_buf_clkgen #(.HALF_PERIOD(CLK_PERIOD / 2)) i_clkgen (.clk_o(clk));

	line_buf i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_en),
		.wr_pos_i  (wr_pos),
		.wr_line_i (wr_line),
		.rd_en_i   (rd_en),
		.rd_pos_i  (rd_pos),
		.rd_line_o (rd_line)
	);

	//**************************************************************************
	// Helpers
	//**************************************************************************

	function automatic line_buf_geom_pkg::blk_pos_t rec_pos(test_rec_t rec);
		line_buf_geom_pkg::blk_pos_t pos;
		pos.size = line_buf_geom_pkg::blk_size_e'(rec.size[1:0]);
		pos.x    = rec.x;
		pos.y    = rec.y;
		pos.idx  = rec.idx[4:0];
		return pos;
	endfunction

	// Eight words from the seeded generator
	function automatic line_buf_data_pkg::line_t random_line();
		line_buf_data_pkg::line_t line;
		for (int w = 0; w < 8; w++)
			line[w*32 +: 32] = $random(seed);
		return line;
	endfunction

	task automatic check_line(input line_buf_data_pkg::line_t exp, input int rec_no);
		assert (rd_line === exp) else begin
			$display("CHECK FAILED rd_line_o record %0d expected %h actual %h",
				rec_no, exp, rd_line);
			$display("Simulation failed");
			$fatal(1, "read line mismatch");
		end
	endtask

	// Drive one record, several records share a cycle through the hold bit
	task automatic apply_record(input test_rec_t rec, input int rec_no);
		line_buf_data_pkg::line_t filler;
		if (rec.op[OP_CHECK_BIT])
			check_line(rec.data, rec_no);
		if (rec.op[OP_WR_BIT]) begin
			wr_en   = 1'b1;
			wr_pos  = rec_pos(rec);
			wr_line = rec.data;
			// 4x4 lines leave the lower 128 bits unused
			if (wr_pos.size == line_buf_geom_pkg::size_4x4) begin
				filler        = random_line();
				wr_line[127:0] = filler[127:0];
			end
		end
		if (rec.op[OP_RD_BIT]) begin
			rd_en      = 1'b1;
			rd_pos     = rec_pos(rec);
			pend_valid = 1'b1;
			pend_exp   = rec.data;
			pend_rec   = rec_no;
		end
	endtask

	//**************************************************************************
	// Stimulus and checks
	//**************************************************************************

	initial begin
		test_rec_t rec;
		int        r;
		seed       = 60812;
		num_recs   = 0;
		rst_n      = 1'b0;
		wr_en      = 1'b0;
		wr_pos     = '0;
		wr_line    = '0;
		rd_en      = 1'b0;
		rd_pos     = '0;
		pend_valid = 1'b0;
		pend_exp   = '0;
		pend_rec   = 0;
		$readmemh("verif/line_buf_tests.txt", tests);
		while (num_recs < MAX_RECS && tests[num_recs][REC_W-1 -: 4] != OP_END)
			num_recs++;
		if (num_recs == MAX_RECS) begin
			$display("Simulation failed");
			$fatal(1, "tests file has no end record");
		end

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		r = 0;
		while (r < num_recs) begin
			@(negedge clk);
			if (pend_valid) begin
				pend_valid = 1'b0;
				check_line(pend_exp, pend_rec);
			end
			wr_en   = 1'b0;
			rd_en   = 1'b0;
			// Noise on the write bus while it is idle
			wr_line = random_line();
			do begin
				rec = test_rec_t'(tests[r]);
				apply_record(rec, r);
				r++;
			end while (rec.op[OP_HOLD_BIT] && r < num_recs);
		end

		// Last read still in flight
		@(negedge clk);
		wr_en = 1'b0;
		rd_en = 1'b0;
		if (pend_valid)
			check_line(pend_exp, pend_rec);
		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog, one clock per record plus reset and a margin
	initial begin
		wait (num_recs > 0);
		#((RESET_CYCLES + num_recs + 8) * CLK_PERIOD);
		$display("Simulation failed");
		$fatal(1, "timeout, test records did not complete");
	end

endmodule

`default_nettype wire

// File: verif/line_buf_tests.txt
// op_size_x_y_idx_data, op bits: 1 write, 2 read, 4 same cycle as next, 8 check output, f end
// data is segments 0 to 3, the write line or the expected read line
8_0_0_0_00_0000000000000000_0000000000000000_0000000000000000_0000000000000000
1_1_0_0_00_100123456789abcd_110123456789abcd_120123456789abcd_130123456789abcd
1_1_2_0_00_200123456789abcd_210123456789abcd_220123456789abcd_230123456789abcd
1_1_4_0_00_300123456789abcd_310123456789abcd_320123456789abcd_330123456789abcd
1_1_6_0_00_400123456789abcd_410123456789abcd_420123456789abcd_430123456789abcd
2_1_0_0_00_100123456789abcd_110123456789abcd_120123456789abcd_130123456789abcd
2_1_2_0_00_200123456789abcd_210123456789abcd_220123456789abcd_230123456789abcd
2_1_4_0_00_300123456789abcd_310123456789abcd_320123456789abcd_330123456789abcd
2_1_6_0_00_400123456789abcd_410123456789abcd_420123456789abcd_430123456789abcd
1_2_0_8_00_500123456789abcd_510123456789abcd_520123456789abcd_530123456789abcd
1_2_4_8_01_600123456789abcd_610123456789abcd_620123456789abcd_630123456789abcd
1_2_0_8_02_700123456789abcd_710123456789abcd_720123456789abcd_730123456789abcd
1_2_4_8_03_800123456789abcd_810123456789abcd_820123456789abcd_830123456789abcd
2_2_0_8_00_500123456789abcd_510123456789abcd_520123456789abcd_530123456789abcd
2_2_4_8_01_600123456789abcd_610123456789abcd_620123456789abcd_630123456789abcd
2_2_0_8_02_700123456789abcd_710123456789abcd_720123456789abcd_730123456789abcd
2_2_4_8_03_800123456789abcd_810123456789abcd_820123456789abcd_830123456789abcd
1_3_8_0_00_900123456789abcd_910123456789abcd_920123456789abcd_930123456789abcd
1_3_8_0_01_a00123456789abcd_a10123456789abcd_a20123456789abcd_a30123456789abcd
1_3_8_0_02_b00123456789abcd_b10123456789abcd_b20123456789abcd_b30123456789abcd
1_3_8_0_03_c00123456789abcd_c10123456789abcd_c20123456789abcd_c30123456789abcd
2_3_8_0_00_900123456789abcd_910123456789abcd_920123456789abcd_930123456789abcd
2_3_8_0_01_a00123456789abcd_a10123456789abcd_a20123456789abcd_a30123456789abcd
2_3_8_0_02_b00123456789abcd_b10123456789abcd_b20123456789abcd_b30123456789abcd
2_3_8_0_03_c00123456789abcd_c10123456789abcd_c20123456789abcd_c30123456789abcd
1_0_2_5_00_a0a1a2a3b0b1b2b3_c0c1c2c3d0d1d2d3_0000000000000000_0000000000000000
1_0_3_5_00_e0e1e2e3f0f1f2f3_7071727360616263_0000000000000000_0000000000000000
2_0_2_5_00_a0a1a2a3e0e1e2e3_b0b1b2b3f0f1f2f3_c0c1c2c370717273_d0d1d2d360616263
5_1_0_0_00_d00123456789abcd_d10123456789abcd_d20123456789abcd_d30123456789abcd
2_1_0_0_00_100123456789abcd_110123456789abcd_120123456789abcd_130123456789abcd
0_0_0_0_00_0000000000000000_0000000000000000_0000000000000000_0000000000000000
2_1_0_0_00_d00123456789abcd_d10123456789abcd_d20123456789abcd_d30123456789abcd
2_3_8_0_01_a00123456789abcd_a10123456789abcd_a20123456789abcd_a30123456789abcd
1_3_8_0_01_e00123456789abcd_e10123456789abcd_e20123456789abcd_e30123456789abcd
0_0_0_0_00_0000000000000000_0000000000000000_0000000000000000_0000000000000000
8_3_8_0_01_a00123456789abcd_a10123456789abcd_a20123456789abcd_a30123456789abcd
2_3_8_0_01_e00123456789abcd_e10123456789abcd_e20123456789abcd_e30123456789abcd
f_0_0_0_00_0000000000000000_0000000000000000_0000000000000000_0000000000000000
